//--- mini_mcu.f
+incdir+.
obi_pkg.sv
mcu_pkg.sv
obi_if.sv
bus_decoder.sv
sram_bank.sv
soc_ctrl.sv
response_mux.sv
mini_mcu.sv
tb_mini_mcu.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mini_mcu
FILELIST  ?= mini_mcu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_mini_mcu.sv
//**************************************************
// self-checking testbench for the mini mcu with a
// reference memory model and random bus traffic
//**************************************************

`timescale 1ns/1ps
`default_nettype none

`include "mini_mcu_config.svh"

module tb_mini_mcu
  import obi_pkg::*;
  import mcu_pkg::*;
;

  localparam int BANK_BYTES = `MCU_BANK_WORDS * 4;
  localparam int FILL_WORDS = `MCU_NUM_BANKS * `MCU_BANK_WORDS;
  localparam int PART_WORDS = 4;
  localparam int N_RAND     = 300;
  localparam int TOTAL_REQS = 2 * FILL_WORDS + 2 * PART_WORDS * `MCU_NUM_BANKS + N_RAND + 12 + 9;
  localparam int MAX_CYCLES = TOTAL_REQS + 200;

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic        bus_req_i;
  logic        bus_we_i;
  logic [3:0]  bus_be_i;
  logic [31:0] bus_addr_i;
  logic [31:0] bus_wdata_i;
  logic        bus_rvalid_o;
  logic [31:0] bus_rdata_o;
  logic        bus_err_o;
  logic        exit_valid_o;
  logic [31:0] exit_value_o;

  // reference state and expected responses as {err, rdata}
  logic [31:0] ref_mem [logic [31:0]];
  logic [31:0] ref_scratch;
  logic [31:0] ref_exit_value;
  logic        ref_exit_valid;
  logic [32:0] exp_q [$];
  logic [32:0] exp_head;
  logic [1:0]  req_pipe;
  logic [31:0] seed;
  logic [31:0] r;
  int          errors;
  int          issued;
  int          checked;
  int          tests;
  int          test_start_errors;
  int          cycles;

  mini_mcu i_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus_req_i   (bus_req_i),
    .bus_we_i    (bus_we_i),
    .bus_be_i    (bus_be_i),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_rvalid_o(bus_rvalid_o),
    .bus_rdata_o (bus_rdata_o),
    .bus_err_o   (bus_err_o),
    .exit_valid_o(exit_valid_o),
    .exit_value_o(exit_value_o)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] rand_word();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic logic [31:0] apply_byte_enables(input logic [31:0] old_word,
                                                     input logic [31:0] new_word,
                                                     input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (new_word & mask) | (old_word & ~mask);
  endfunction

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    errors++;
  endtask

  // memory map rules applied to the reference state
  task automatic model_access(input obi_op_e op, input logic [3:0] be, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic err,
                              output logic [31:0] rdata);
    logic [31:0] ofs;
    logic [31:0] old_word;
    ofs   = addr - MCU_SOC_BASE;
    err   = 1'b0;
    rdata = '0;
    if (addr[1:0] != 2'b00) begin
      err = 1'b1;
    end else if (addr < MCU_BANK_SPAN) begin
      old_word = ref_mem.exists(addr) ? ref_mem[addr] : '0;
      if (op == OBI_WRITE) ref_mem[addr] = apply_byte_enables(old_word, wdata, be);
      else rdata = old_word;
    end else if (addr >= MCU_SOC_BASE && ofs < 32'd12) begin
      case (soc_reg_e'(ofs[3:2]))
        SOC_EXIT_VALUE: begin
          if (op == OBI_WRITE) begin
            ref_exit_value = apply_byte_enables(ref_exit_value, wdata, be);
            ref_exit_valid = 1'b1;
          end else begin
            rdata = ref_exit_value;
          end
        end
        SOC_SCRATCH: begin
          if (op == OBI_WRITE) ref_scratch = apply_byte_enables(ref_scratch, wdata, be);
          else rdata = ref_scratch;
        end
        default: if (op == OBI_READ) rdata = {31'd0, ref_exit_valid};
      endcase
    end else begin
      err = 1'b1;
    end
  endtask

  task automatic issue(input obi_op_e op, input logic [3:0] be, input logic [31:0] addr,
                       input logic [31:0] wdata);
    logic        err;
    logic [31:0] rdata;
    @(posedge clk_i);
    bus_req_i   <= 1'b1;
    bus_we_i    <= (op == OBI_WRITE);
    bus_be_i    <= be;
    bus_addr_i  <= addr;
    bus_wdata_i <= wdata;
    model_access(op, be, addr, wdata, err, rdata);
    exp_q.push_back({err, rdata});
    issued++;
  endtask

  task automatic drain();
    @(posedge clk_i);
    bus_req_i <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk_i);
  endtask

  task automatic end_test(input string name);
    drain();
    tests++;
    $display("test %0d %-28s %0d errors", tests, name, errors - test_start_errors);
    test_start_errors = errors;
  endtask

  // every response lands 2 cycles after its request and matches the queue head
  always @(negedge clk_i) begin
    if (rst_i) begin
      req_pipe <= 2'b00;
    end else begin
      assert (bus_rvalid_o == req_pipe[1])
        else report_mismatch("bus_rvalid_o not exactly 2 cycles after bus_req_i");
      if (bus_rvalid_o) begin
        if (exp_q.size() == 0) begin
          $display("error at %0t: response arrived with no request outstanding", $time);
          errors++;
        end else begin
          exp_head = exp_q.pop_front();
          checked++;
          assert ({bus_err_o, bus_rdata_o} == exp_head) else begin
            $display("mismatch at %0t: got err %0b rdata %08h, expected err %0b rdata %08h",
                     $time, bus_err_o, bus_rdata_o, exp_head[32], exp_head[31:0]);
            errors++;
          end
        end
      end else begin
        assert (!bus_err_o) else report_mismatch("bus_err_o high without bus_rvalid_o");
      end
      req_pipe <= {req_pipe[0], bus_req_i};
    end
  end

  initial begin
    rst_i <= 1'b1;
    bus_req_i <= 1'b0;
    bus_we_i <= 1'b0;
    bus_be_i <= '0;
    bus_addr_i <= '0;
    bus_wdata_i <= '0;
    seed = 32'hae82_546e;
    ref_scratch = '0;
    ref_exit_value = '0;
    ref_exit_valid = 1'b0;
    errors = 0;
    issued = 0;
    checked = 0;
    tests = 0;
    test_start_errors = 0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    @(negedge clk_i);
    assert (!bus_rvalid_o && !bus_err_o && !exit_valid_o && exit_value_o == '0)
      else report_mismatch("outputs not idle after reset");
    end_test("reset state");

    // full fill also gives the random test defined contents
    for (int i = 0; i < FILL_WORDS; i++) issue(OBI_WRITE, 4'hf, i * 4, fill_word(i * 4));
    for (int i = 0; i < FILL_WORDS; i++) issue(OBI_READ, 4'hf, i * 4, '0);
    for (int k = 0; k < `MCU_NUM_BANKS; k++) begin
      for (int j = 0; j < PART_WORDS; j++) begin
        r = rand_word();
        issue(OBI_WRITE, r[27:24], k * BANK_BYTES + j * 36, rand_word());
      end
    end
    for (int k = 0; k < `MCU_NUM_BANKS; k++) begin
      for (int j = 0; j < PART_WORDS; j++) issue(OBI_READ, 4'hf, k * BANK_BYTES + j * 36, '0);
    end
    end_test("bank write and read");

    for (int i = 0; i < N_RAND; i++) begin
      r = rand_word();
      issue(obi_op_e'(r[20]), r[27:24], (rand_word() % MCU_BANK_SPAN) & 32'hffff_fffc,
            rand_word());
    end
    end_test("back-to-back random");

    issue(OBI_WRITE, 4'hf, MCU_BANK_SPAN, 32'h1111_1111);
    issue(OBI_WRITE, 4'hf, 32'h1000_0000, 32'h2222_2222);
    issue(OBI_WRITE, 4'hf, MCU_SOC_BASE - 32'd4, 32'h3333_3333);
    issue(OBI_WRITE, 4'hf, MCU_SOC_BASE + 32'd12, 32'h4444_4444);
    issue(OBI_WRITE, 4'hf, MCU_SOC_BASE + 32'd16, 32'h5555_5555);
    issue(OBI_WRITE, 4'hf, 32'hffff_fffc, 32'h6666_6666);
    issue(OBI_WRITE, 4'hf, 32'h0000_0011, 32'h7777_7777);
    issue(OBI_WRITE, 4'hf, BANK_BYTES + 2, 32'h8888_8888);
    issue(OBI_READ, 4'hf, 32'h0000_0013, '0);
    issue(OBI_READ, 4'hf, MCU_SOC_BASE + 32'd12, '0);
    issue(OBI_READ, 4'hf, 32'h0000_0010, '0);
    issue(OBI_READ, 4'hf, BANK_BYTES, '0);
    end_test("decode errors");

    issue(OBI_WRITE, 4'hf, MCU_SOC_BASE + 32'd4, 32'hdead_beef);
    issue(OBI_READ, 4'hf, MCU_SOC_BASE + 32'd4, '0);
    issue(OBI_WRITE, 4'b0010, MCU_SOC_BASE + 32'd4, 32'h0000_1200);
    issue(OBI_READ, 4'hf, MCU_SOC_BASE + 32'd4, '0);
    issue(OBI_READ, 4'hf, MCU_SOC_BASE + 32'd8, '0);
    drain();
    assert (!exit_valid_o) else report_mismatch("exit_valid_o set before any exit write");
    issue(OBI_WRITE, 4'hf, MCU_SOC_BASE, 32'h0000_002a);
    issue(OBI_READ, 4'hf, MCU_SOC_BASE + 32'd8, '0);
    issue(OBI_WRITE, 4'hf, MCU_SOC_BASE + 32'd8, 32'h0000_0000);
    issue(OBI_READ, 4'hf, MCU_SOC_BASE, '0);
    drain();
    assert (exit_valid_o && exit_value_o == ref_exit_value)
      else report_mismatch("exit outputs do not follow the exit value write");
    end_test("soc control registers");

    $display("summary: %0d tests, %0d requests, %0d responses checked, %0d errors",
             tests, issued, checked, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule  // tb_mini_mcu

`default_nettype wire

//--- mini_mcu.sv
//**************************************************
// mini_mcu: bus decoder, sram banks, soc control
// and response mux behind one plain-port bus
//**************************************************

`timescale 1ns/1ps
`default_nettype none

`include "mini_mcu_config.svh"

module mini_mcu
  import obi_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_i,

  input  logic               bus_req_i,
  input  logic               bus_we_i,
  input  logic [OBI_BEW-1:0] bus_be_i,
  input  logic [OBI_AW-1:0]  bus_addr_i,
  input  logic [OBI_DW-1:0]  bus_wdata_i,
  output logic               bus_rvalid_o,
  output logic [OBI_DW-1:0]  bus_rdata_o,
  output logic               bus_err_o,

  output logic               exit_valid_o,
  output logic [OBI_DW-1:0]  exit_value_o
);

  // one bus per bank plus the soc control bus
  obi_if bank_bus [`MCU_NUM_BANKS] ();
  obi_if soc_bus ();

  logic err_valid;

  bus_decoder bus_decoder_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (bus_req_i),
    .we_i       (bus_we_i),
    .be_i       (bus_be_i),
    .addr_i     (bus_addr_i),
    .wdata_i    (bus_wdata_i),
    .bank_o     (bank_bus),
    .soc_o      (soc_bus),
    .err_valid_o(err_valid)
  );

  for (genvar k = 0; k < `MCU_NUM_BANKS; k++) begin : g_bank
    sram_bank sram_bank_i (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .bus_i(bank_bus[k])
    );
  end

  soc_ctrl soc_ctrl_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus_i       (soc_bus),
    .exit_valid_o(exit_valid_o),
    .exit_value_o(exit_value_o)
  );

  response_mux response_mux_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .bank_i     (bank_bus),
    .soc_i      (soc_bus),
    .err_valid_i(err_valid),
    .rvalid_o   (bus_rvalid_o),
    .rdata_o    (bus_rdata_o),
    .err_o      (bus_err_o)
  );

endmodule  // mini_mcu

`default_nettype wire

//--- response_mux.sv
//**************************************************
// response_mux: merges bank, soc and error answers
// into one registered response stream
//**************************************************

`timescale 1ns/1ps
`default_nettype none

`include "mini_mcu_config.svh"

module response_mux
  import obi_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  obi_if.monitor            bank_i [`MCU_NUM_BANKS],
  obi_if.monitor            soc_i,
  input  logic              err_valid_i,
  output logic              rvalid_o,
  output logic [OBI_DW-1:0] rdata_o,
  output logic              err_o
);

  logic [`MCU_NUM_BANKS-1:0] bank_valid;
  logic [OBI_DW-1:0]         bank_rdata [`MCU_NUM_BANKS];
  logic [OBI_DW-1:0]         rdata_d;
  logic                      valid_d;

  for (genvar k = 0; k < `MCU_NUM_BANKS; k++) begin : g_collect
    assign bank_valid[k] = bank_i[k].rvalid;
    assign bank_rdata[k] = bank_i[k].rdata;
  end

  // sources are one-hot, so an and-or select is enough
  always_comb begin
    rdata_d = '0;
    for (int k = 0; k < `MCU_NUM_BANKS; k++) begin
      if (bank_valid[k]) rdata_d = rdata_d | bank_rdata[k];
    end
    if (soc_i.rvalid) rdata_d = rdata_d | soc_i.rdata;
  end

  assign valid_d = (|bank_valid) | soc_i.rvalid | err_valid_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
    end else begin
      rvalid_o <= valid_d;
      err_o    <= err_valid_i;
    end
  end

  // zero whenever no data source answers, error included
  always_ff @(posedge clk_i) begin
    rdata_o <= rdata_d;
  end

endmodule  // response_mux

`default_nettype wire

//--- soc_ctrl.sv
//**************************************************
// soc_ctrl: exit value, exit valid and scratch
// registers on the system bus
//**************************************************

`timescale 1ns/1ps
`default_nettype none

module soc_ctrl
  import obi_pkg::*;
  import mcu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  obi_if.slave              bus_i,
  output logic              exit_valid_o,
  output logic [OBI_DW-1:0] exit_value_o
);

  logic [OBI_DW-1:0] exit_value_q;
  logic [OBI_DW-1:0] scratch_q;
  logic              exit_valid_q;
  soc_reg_e          reg_idx;
  obi_op_e           op;

  // soc base is 16-byte aligned, so bits 3:2 give the register
  assign reg_idx = soc_reg_e'(bus_i.addr[3:2]);
  assign op      = obi_op_e'(bus_i.we);

  function automatic logic [OBI_DW-1:0] be_merge(input logic [OBI_DW-1:0]  old_word,
                                                 input logic [OBI_DW-1:0]  new_word,
                                                 input logic [OBI_BEW-1:0] be);
    logic [OBI_DW-1:0] res;
    res = old_word;
    for (int b = 0; b < OBI_BEW; b++) begin
      if (be[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      scratch_q    <= '0;
    end else if (bus_i.req && op == OBI_WRITE) begin
      case (reg_idx)
        SOC_EXIT_VALUE: begin
          exit_value_q <= be_merge(exit_value_q, bus_i.wdata, bus_i.be);
          // sticky until reset
          exit_valid_q <= 1'b1;
        end
        SOC_SCRATCH: scratch_q <= be_merge(scratch_q, bus_i.wdata, bus_i.be);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      if (op == OBI_WRITE) begin
        bus_i.rdata <= '0;
      end else begin
        case (reg_idx)
          SOC_EXIT_VALUE:  bus_i.rdata <= exit_value_q;
          SOC_SCRATCH:     bus_i.rdata <= scratch_q;
          SOC_EXIT_STATUS: bus_i.rdata <= {{(OBI_DW-1){1'b0}}, exit_valid_q};
          default:         bus_i.rdata <= '0;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bus_i.rvalid <= 1'b0;
    end else begin
      bus_i.rvalid <= bus_i.req;
    end
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule  // soc_ctrl

`default_nettype wire

//--- sram_bank.sv
//**************************************************
// sram_bank: one word-wide memory bank, byte
// enable writes and one-cycle read latency
//**************************************************

`timescale 1ns/1ps
`default_nettype none

`include "mini_mcu_config.svh"

module sram_bank
  import obi_pkg::*;
  import mcu_pkg::*;
(
  input  logic clk_i,
  input  logic rst_i,
  obi_if.slave bus_i
);

  logic [OBI_DW-1:0]      mem_q [`MCU_BANK_WORDS];
  logic [MCU_BANK_AW-1:0] word_idx;
  obi_op_e                op;

  assign word_idx = bus_i.addr[MCU_BANK_OFS_W-1:2];
  assign op       = obi_op_e'(bus_i.we);

  // byte lanes written independently
  always_ff @(posedge clk_i) begin
    if (bus_i.req && op == OBI_WRITE) begin
      for (int b = 0; b < OBI_BEW; b++) begin
        if (bus_i.be[b]) begin
          mem_q[word_idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // write response returns zero
  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      bus_i.rdata <= (op == OBI_READ) ? mem_q[word_idx] : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bus_i.rvalid <= 1'b0;
    end else begin
      bus_i.rvalid <= bus_i.req;
    end
  end

endmodule  // sram_bank

`default_nettype wire

//--- bus_decoder.sv
//**************************************************
// bus_decoder: routes each request to one sram
// bank, the soc control block or the error path
//**************************************************

`timescale 1ns/1ps
`default_nettype none

`include "mini_mcu_config.svh"

module bus_decoder
  import obi_pkg::*;
  import mcu_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_i,

  input  logic               req_i,
  input  logic               we_i,
  input  logic [OBI_BEW-1:0] be_i,
  input  logic [OBI_AW-1:0]  addr_i,
  input  logic [OBI_DW-1:0]  wdata_i,

  obi_if.master              bank_o [`MCU_NUM_BANKS],
  obi_if.master              soc_o,

  output logic               err_valid_o
);

  mcu_region_e               region;
  logic [OBI_AW-1:0]         soc_ofs;
  logic [MCU_BANK_SEL_W-1:0] bank_sel;

  assign soc_ofs  = addr_i - MCU_SOC_BASE;
  assign bank_sel = addr_i[OBI_AW-1:MCU_BANK_OFS_W];

  // classify the address, misaligned accesses go to the error path
  always_comb begin
    region = REGION_ERR;
    if (addr_i[1:0] == 2'b00) begin
      if (addr_i < MCU_BANK_SPAN) begin
        region = REGION_BANK;
      end else if (addr_i >= MCU_SOC_BASE && soc_ofs < MCU_SOC_SPAN &&
                   soc_ofs[3:2] <= SOC_EXIT_STATUS) begin
        region = REGION_SOC;
      end
    end
  end

  // one strobe per bank, payload fans out to all of them
  for (genvar k = 0; k < `MCU_NUM_BANKS; k++) begin : g_bank
    assign bank_o[k].req   = req_i && (region == REGION_BANK) &&
                             (bank_sel == MCU_BANK_SEL_W'(k));
    assign bank_o[k].we    = we_i;
    assign bank_o[k].be    = be_i;
    assign bank_o[k].addr  = addr_i;
    assign bank_o[k].wdata = wdata_i;
  end

  assign soc_o.req   = req_i && (region == REGION_SOC);
  assign soc_o.we    = we_i;
  assign soc_o.be    = be_i;
  assign soc_o.addr  = addr_i;
  assign soc_o.wdata = wdata_i;

  // error answer lines up with the one-cycle slave latency
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_valid_o <= 1'b0;
    end else begin
      err_valid_o <= req_i && (region == REGION_ERR);
    end
  end

endmodule  // bus_decoder

`default_nettype wire

//--- obi_if.sv
//**************************************************
// obi_if: internal request/response bus between
// the decoder, the slaves and the response mux
//**************************************************

`timescale 1ns/1ps
`default_nettype none

interface obi_if
  import obi_pkg::*;
();

  // request side, one-cycle strobe, no grant
  logic               req;
  logic               we;
  logic [OBI_BEW-1:0] be;
  logic [OBI_AW-1:0]  addr;
  logic [OBI_DW-1:0]  wdata;

  // response side
  logic               rvalid;
  logic [OBI_DW-1:0]  rdata;

  modport master(output req, we, be, addr, wdata);
  modport slave(input req, we, be, addr, wdata, output rvalid, rdata);
  modport monitor(input rvalid, rdata);

endinterface  // obi_if

`default_nettype wire

//--- mcu_pkg.sv
//**************************************************
// mcu_pkg: memory map regions, soc register map
// and address helper constants
//**************************************************

`default_nettype none

`include "mini_mcu_config.svh"

package mcu_pkg;
  import obi_pkg::*;

  // decode target of a request
  typedef enum logic [1:0] {
    REGION_BANK = 2'd0,
    REGION_SOC  = 2'd1,
    REGION_ERR  = 2'd2
  } mcu_region_e;

  // soc register index, word offset inside the soc block
  typedef enum logic [1:0] {
    SOC_EXIT_VALUE  = 2'd0,
    SOC_SCRATCH     = 2'd1,
    SOC_EXIT_STATUS = 2'd2
  } soc_reg_e;

  // word index bits inside a bank and byte offset bits of a bank
  localparam int unsigned MCU_BANK_AW    = $clog2(`MCU_BANK_WORDS);
  localparam int unsigned MCU_BANK_OFS_W = MCU_BANK_AW + 2;
  localparam int unsigned MCU_BANK_SEL_W = OBI_AW - MCU_BANK_OFS_W;

  localparam logic [OBI_AW-1:0] MCU_BANK_SPAN = `MCU_NUM_BANKS * `MCU_BANK_WORDS * 4;
  localparam logic [OBI_AW-1:0] MCU_SOC_BASE  = `MCU_SOC_BASE;
  localparam logic [OBI_AW-1:0] MCU_SOC_SPAN  = 32'd16;

endpackage  // mcu_pkg

`default_nettype wire

//--- obi_pkg.sv
//**************************************************
// obi_pkg: system bus widths and operation codes
//**************************************************

`default_nettype none

package obi_pkg;

  // address, data and byte enable widths
  localparam int unsigned OBI_AW  = 32;
  localparam int unsigned OBI_DW  = 32;
  localparam int unsigned OBI_BEW = OBI_DW / 8;

  // bus operation, taken straight from we
  typedef enum logic {
    OBI_READ  = 1'b0,
    OBI_WRITE = 1'b1
  } obi_op_e;

endpackage  // obi_pkg

`default_nettype wire

//--- mini_mcu_config.svh
//**************************************************
// mini mcu build configuration
// bank count, bank depth and SoC control base
//**************************************************

`ifndef MINI_MCU_CONFIG_SVH
`define MINI_MCU_CONFIG_SVH

// number of sram banks on the bus
`define MCU_NUM_BANKS 2

// words per bank, keep a power of two
`define MCU_BANK_WORDS 256

// byte base of the soc control registers, 16-byte aligned
`define MCU_SOC_BASE 32'h2000_0000

`endif
